// ==== logic/patch_pkg.sv ====
package patch_pkg;

    // core counts
    localparam int NUM_RT = 4;
    localparam int NUM_IC = 4;

    // one patch fills each queue exactly
    localparam int NUM_THREAD = 32;
    localparam int THREAD_W = $clog2(NUM_THREAD);

    // one extra bit so a full patch of 32 fits
    localparam int CNT_W = THREAD_W + 1;

    // pixel id, pc and sp share this width
    localparam int PIXEL_W = 32;

    // context an RT core hands over on a switch
    typedef struct packed {
        logic [THREAD_W-1:0] tid;
        logic [PIXEL_W-1:0] pc;
        logic [PIXEL_W-1:0] sp;
    } rt_context_t;

    // job sent to an RT core on dispatch
    // head thread id plus its stored state
    typedef struct packed {
        logic [THREAD_W-1:0] tid;
        logic [PIXEL_W-1:0] pixel_id;
        logic [PIXEL_W-1:0] pc;
        logic [PIXEL_W-1:0] sp;
    } rt_job_t;

endpackage

// ==== logic/patch_dispatcher_fifo.sv ====
`timescale 1ns/1ps

module patch_dispatcher_fifo (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           en_q,
    input  logic                           de_q,
    input  logic [patch_pkg::THREAD_W-1:0] data_in,
    output logic                           empty,
    output logic [patch_pkg::THREAD_W-1:0] data_out
);
    import patch_pkg::*;

    // pointers carry one wrap bit above the address
    logic [THREAD_W:0] wr_ptr;
    logic [THREAD_W:0] rd_ptr;

    // thread id storage
    logic [THREAD_W-1:0] mem [NUM_THREAD];

    // write pointer advances on every enqueue
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (en_q) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read pointer advances on every dequeue
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (de_q) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // tail write
    always_ff @(posedge clk) begin
        if (en_q) begin
            mem[wr_ptr[THREAD_W-1:0]] <= data_in;
        end
    end

    // head shows without a read cycle
    assign data_out = mem[rd_ptr[THREAD_W-1:0]];

    // equal pointers incl. wrap bit means nothing stored
    assign empty = (wr_ptr == rd_ptr);

endmodule

// ==== logic/switch_arbiter.sv ====
`timescale 1ns/1ps

module switch_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [patch_pkg::NUM_RT-1:0] request,
    input  logic                         hold,
    output logic [patch_pkg::NUM_RT-1:0] grant
);
    import patch_pkg::*;

    // requests seen but not yet granted
    logic [NUM_RT-1:0] pending;

    // a new pulse competes in its own cycle
    logic [NUM_RT-1:0] active;

    // lowest set bit of active
    logic [NUM_RT-1:0] lowest;

    assign active = request | pending;

    // two's complement trick isolates bit 0 side winner
    assign lowest = active & (~active + 1'b1);

    // nothing leaves while held
    assign grant = hold ? '0 : lowest;

    // keep every loser and every held request
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= active & ~grant;
        end
    end

    // a core holds its request data until its grant bit
    // so losing a cycle here costs nothing but latency

endmodule

// ==== logic/thread_context_store.sv ====
`timescale 1ns/1ps

module thread_context_store (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pixel_we,
    input  logic [patch_pkg::THREAD_W-1:0] pixel_addr,
    input  logic [patch_pkg::PIXEL_W-1:0]  pixel_id,
    input  logic                           ctx_we,
    input  patch_pkg::rt_context_t         ctx,
    input  logic [patch_pkg::THREAD_W-1:0] rd_thread,
    output patch_pkg::rt_job_t             rd_job
);
    import patch_pkg::*;

    // per-thread tables
    logic [PIXEL_W-1:0] pixel_tab [NUM_THREAD];
    logic [PIXEL_W-1:0] pc_tab [NUM_THREAD];
    logic [PIXEL_W-1:0] sp_tab [NUM_THREAD];

    // pixel ids come from the command processor during load
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_THREAD; i++) begin
                pixel_tab[i] <= '0;
            end
        end else if (pixel_we) begin
            pixel_tab[pixel_addr] <= pixel_id;
        end
    end

    // pc and sp saved on an RT switch grant
    // a freshly loaded thread starts from zero
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_THREAD; i++) begin
                pc_tab[i] <= '0;
                sp_tab[i] <= '0;
            end
        end else begin
            if (pixel_we) begin
                pc_tab[pixel_addr] <= '0;
                sp_tab[pixel_addr] <= '0;
            end
            if (ctx_we) begin
                pc_tab[ctx.tid] <= ctx.pc;
                sp_tab[ctx.tid] <= ctx.sp;
            end
        end
    end

    // fresh threads read back zero pc and sp
    // returning threads read back their saved state
    always_comb begin
        rd_job.tid      = rd_thread;
        rd_job.pixel_id = pixel_tab[rd_thread];
        rd_job.pc       = pc_tab[rd_thread];
        rd_job.sp       = sp_tab[rd_thread];
    end

endmodule

// ==== logic/patch_loader.sv ====
`timescale 1ns/1ps

module patch_loader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load_cp,
    input  logic                           load_done_cp,
    input  logic [patch_pkg::NUM_RT-1:0]   task_done_rt,
    output logic                           loading,
    output logic                           load_we,
    output logic [patch_pkg::THREAD_W-1:0] load_addr,
    output logic                           patch_done
);
    import patch_pkg::*;

    typedef enum logic {LD_IDLE, LD_LOADING} load_state_t;

    load_state_t state;
    load_state_t state_nxt;

    // threads loaded and threads finished in this patch
    logic [CNT_W-1:0] load_cnt;
    logic [CNT_W-1:0] done_cnt;

    // finished tasks this cycle
    logic [CNT_W-1:0] done_sum;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= LD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // first pixel rides with load_cp
    // the load_done_cp cycle carries no pixel
    always_comb begin
        state_nxt = state;
        load_we   = 1'b0;
        case (state)
            LD_IDLE: begin
                if (load_cp) begin
                    state_nxt = LD_LOADING;
                    load_we   = 1'b1;
                end
            end
            default: begin
                if (load_done_cp) begin
                    state_nxt = LD_IDLE;
                end else begin
                    load_we = 1'b1;
                end
            end
        endcase
    end

    // covers the load_cp cycle too
    assign loading = load_cp || (state == LD_LOADING);

    assign load_addr = load_cnt[THREAD_W-1:0];

    always_comb begin
        done_sum = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            done_sum = done_sum + CNT_W'(task_done_rt[i]);
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            load_cnt <= '0;
            done_cnt <= '0;
        end else if (patch_done) begin
            load_cnt <= '0;
            done_cnt <= '0;
        end else begin
            load_cnt <= load_cnt + CNT_W'(load_we);
            done_cnt <= done_cnt + done_sum;
        end
    end

    // empty patch never counts as done
    assign patch_done = (done_cnt == load_cnt) && (load_cnt != '0);

endmodule

// ==== logic/patch_dispatcher.sv ====
`timescale 1ns/1ps

module patch_dispatcher (
    input  logic                           clk,
    input  logic                           rst_n,

    // command processor
    input  logic                           load_cp,
    input  logic                           load_done_cp,
    input  logic [patch_pkg::PIXEL_W-1:0]  pixel_id_cp,

    // from RT cores
    input  logic [patch_pkg::NUM_RT-1:0]   task_done_rt,
    input  logic [patch_pkg::NUM_RT-1:0]   context_switch_rt,
    input  patch_pkg::rt_context_t         rt_ctx_in [patch_pkg::NUM_RT],

    // from IC cores
    input  logic [patch_pkg::NUM_IC-1:0]   context_switch_ic,
    input  logic [patch_pkg::THREAD_W-1:0] thread_id_in_ic [patch_pkg::NUM_IC],

    output logic                           patch_done,

    // to RT cores
    output logic [patch_pkg::NUM_RT-1:0]   job_dispatch_rt,
    output patch_pkg::rt_job_t             rt_job,

    // to IC cores
    output logic [patch_pkg::NUM_IC-1:0]   job_dispatch_ic,
    output logic [patch_pkg::THREAD_W-1:0] thread_id_out_ic,

    // switch grants back to the requesting core
    output logic [patch_pkg::NUM_RT-1:0]   core_id_rt2ic,
    output logic [patch_pkg::NUM_IC-1:0]   core_id_ic2rt
);
    import patch_pkg::*;

    // loader
    logic                loading;
    logic                load_we;
    logic [THREAD_W-1:0] load_addr;

    // core state
    logic [NUM_RT-1:0] busy_rt;
    logic [NUM_IC-1:0] busy_ic;
    logic [NUM_RT-1:0] free_rt;
    logic [NUM_IC-1:0] free_ic;

    // RT queue, fed by loader or IC grants
    logic                rt_q_en;
    logic                rt_q_de;
    logic [THREAD_W-1:0] rt_q_din;
    logic                rt_q_empty;
    logic [THREAD_W-1:0] rt_q_head;

    // IC queue, fed by RT grants
    logic                ic_q_en;
    logic                ic_q_de;
    logic                ic_q_empty;
    logic [THREAD_W-1:0] ic_q_head;

    // switch arbitration
    logic [NUM_RT-1:0]   rt_grant;
    logic [NUM_IC-1:0]   ic_grant;
    rt_context_t         rt_ctx_sel;
    logic [THREAD_W-1:0] ic_tid_sel;

    patch_loader loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_cp      (load_cp),
        .load_done_cp (load_done_cp),
        .task_done_rt (task_done_rt),
        .loading      (loading),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .patch_done   (patch_done)
    );

    // RT side never waits on the loader
    switch_arbiter rt_switch (
        .clk     (clk),
        .rst_n   (rst_n),
        .request (context_switch_rt),
        .hold    (1'b0),
        .grant   (rt_grant)
    );

    // held during load so the RT queue has one writer
    switch_arbiter ic_switch (
        .clk     (clk),
        .rst_n   (rst_n),
        .request (context_switch_ic),
        .hold    (loading),
        .grant   (ic_grant)
    );

    assign core_id_rt2ic = rt_grant;
    assign core_id_ic2rt = ic_grant;

    // grants are one-hot so a plain priority mux is enough
    always_comb begin
        rt_ctx_sel = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            if (rt_grant[i]) begin
                rt_ctx_sel = rt_ctx_in[i];
            end
        end
    end

    always_comb begin
        ic_tid_sel = '0;
        for (int i = 0; i < NUM_IC; i++) begin
            if (ic_grant[i]) begin
                ic_tid_sel = thread_id_in_ic[i];
            end
        end
    end

    thread_context_store store (
        .clk        (clk),
        .rst_n      (rst_n),
        .pixel_we   (load_we),
        .pixel_addr (load_addr),
        .pixel_id   (pixel_id_cp),
        .ctx_we     (|rt_grant),
        .ctx        (rt_ctx_sel),
        .rd_thread  (rt_q_head),
        .rd_job     (rt_job)
    );

    // loader wins, though the IC hold already keeps them apart
    assign rt_q_en  = load_we || (|ic_grant);
    assign rt_q_din = load_we ? load_addr : ic_tid_sel;

    patch_dispatcher_fifo rt_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_q     (rt_q_en),
        .de_q     (rt_q_de),
        .data_in  (rt_q_din),
        .empty    (rt_q_empty),
        .data_out (rt_q_head)
    );

    assign ic_q_en = |rt_grant;

    patch_dispatcher_fifo ic_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_q     (ic_q_en),
        .de_q     (ic_q_de),
        .data_in  (rt_ctx_sel.tid),
        .empty    (ic_q_empty),
        .data_out (ic_q_head)
    );

    // lowest free core takes the head
    assign free_rt = ~busy_rt;
    assign free_ic = ~busy_ic;

    // no RT dispatch while pixels still load
    assign job_dispatch_rt = (rt_q_empty || loading) ? '0 : (free_rt & (~free_rt + 1'b1));
    assign job_dispatch_ic = ic_q_empty ? '0 : (free_ic & (~free_ic + 1'b1));

    // pop only when a core actually took it
    assign rt_q_de = |job_dispatch_rt;
    assign ic_q_de = |job_dispatch_ic;

    assign thread_id_out_ic = ic_q_head;

    // dispatch sets busy
    // switch grant or task done clears it
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy_rt <= '0;
        end else begin
            busy_rt <= busy_rt ^ (job_dispatch_rt | rt_grant | task_done_rt);
        end
    end

    // IC threads always return through a switch
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy_ic <= '0;
        end else begin
            busy_ic <= busy_ic ^ (job_dispatch_ic | ic_grant);
        end
    end

endmodule

// ==== testbench/patch_dispatcher_tb.sv ====
`timescale 1ns/1ps

module patch_dispatcher_tb;
    import patch_pkg::*;

    logic clk;
    logic rst_n;
    logic load_cp;
    logic load_done_cp;
    logic [PIXEL_W-1:0] pixel_id_cp;
    logic [NUM_RT-1:0] task_done_rt;
    logic [NUM_RT-1:0] context_switch_rt;
    rt_context_t rt_ctx_in [NUM_RT];
    logic [NUM_IC-1:0] context_switch_ic;
    logic [THREAD_W-1:0] thread_id_in_ic [NUM_IC];
    logic patch_done;
    logic [NUM_RT-1:0] job_dispatch_rt;
    rt_job_t rt_job;
    logic [NUM_IC-1:0] job_dispatch_ic;
    logic [THREAD_W-1:0] thread_id_out_ic;
    logic [NUM_RT-1:0] core_id_rt2ic;
    logic [NUM_IC-1:0] core_id_ic2rt;

    // core model state
    // 0 idle, 1 working, 2 waiting for grant, 3 finishing
    int rt_st [NUM_RT];
    int rt_cnt [NUM_RT];
    logic [THREAD_W-1:0] rt_tid [NUM_RT];
    int ic_st [NUM_IC];
    int ic_cnt [NUM_IC];

    // scoreboard
    int q_rt [$];
    int q_ic [$];
    logic [PIXEL_W-1:0] exp_pix [NUM_THREAD];
    logic [PIXEL_W-1:0] exp_pc [NUM_THREAD];
    logic [PIXEL_W-1:0] exp_sp [NUM_THREAD];
    int sw_cnt [NUM_THREAD];
    int fin_cnt [NUM_THREAD];
    int done_total;
    int cur_n;
    int errors;
    int tests;
    bit loading_tb;
    bit stall_rt;
    bit patch_seen;
    bit timed_out;

    patch_dispatcher dut0 (.*);

    always #2 clk = ~clk;

    function automatic logic [3:0] first_set(input logic [3:0] v);
        for (int i = 0; i < 4; i++) begin
            if (v[i]) return 4'(1 << i);
        end
        return '0;
    endfunction

    // protocol rules
    a_no_load_dispatch: assert property (@(posedge clk) disable iff (!rst_n)
        loading_tb |-> job_dispatch_rt == '0)
        else begin
            errors++;
            $display("dispatch to RT while loading");
        end
    a_dispatch_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(job_dispatch_rt) && $onehot0(job_dispatch_ic))
        else begin
            errors++;
            $display("dispatch vector not one-hot");
        end
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(core_id_rt2ic) && $onehot0(core_id_ic2rt))
        else begin
            errors++;
            $display("switch grant not one-hot");
        end
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        patch_done |=> !patch_done)
        else begin
            errors++;
            $display("patch_done longer than one cycle");
        end

    // core models and scoreboard
    always @(posedge clk) begin
        logic [3:0] d_rt;
        logic [3:0] d_ic;
        logic [3:0] g_rt;
        logic [3:0] g_ic;
        logic [3:0] td;
        logic [3:0] idle_rt;
        logic [3:0] idle_ic;
        logic [3:0] wait_rt;
        logic [3:0] wait_ic;
        logic [3:0] exp_g_ic;
        rt_job_t job;
        logic [THREAD_W-1:0] ic_out;
        logic pd;
        logic exp_pd;
        int exp_tid;
        if (rst_n) begin
            d_rt = job_dispatch_rt;
            d_ic = job_dispatch_ic;
            g_rt = core_id_rt2ic;
            g_ic = core_id_ic2rt;
            td = task_done_rt;
            job = rt_job;
            ic_out = thread_id_out_ic;
            pd = patch_done;
            for (int i = 0; i < 4; i++) begin
                idle_rt[i] = (rt_st[i] == 0);
                idle_ic[i] = (ic_st[i] == 0);
                wait_rt[i] = (rt_st[i] == 2);
                wait_ic[i] = (ic_st[i] == 2);
            end
            // head goes to lowest free core
            if (d_rt != '0) begin
                assert (d_rt == first_set(idle_rt)) else begin
                    errors++;
                    $display("Error: job_dispatch_rt exp %h got %h", first_set(idle_rt), d_rt);
                end
                exp_tid = (q_rt.size() > 0) ? q_rt.pop_front() : -1;
                assert (int'(job.tid) == exp_tid) else begin
                    errors++;
                    $display("Error: rt_job.tid exp %h got %h", exp_tid, job.tid);
                end
                assert (job.pixel_id == exp_pix[job.tid] && job.pc == exp_pc[job.tid]
                        && job.sp == exp_sp[job.tid]) else begin
                    errors++;
                    $display("Error: rt_job exp %h %h %h got %h %h %h", exp_pix[job.tid],
                             exp_pc[job.tid], exp_sp[job.tid], job.pixel_id, job.pc, job.sp);
                end
            end
            if (d_ic != '0) begin
                assert (d_ic == first_set(idle_ic)) else begin
                    errors++;
                    $display("Error: job_dispatch_ic exp %h got %h", first_set(idle_ic), d_ic);
                end
                exp_tid = (q_ic.size() > 0) ? q_ic.pop_front() : -1;
                assert (int'(ic_out) == exp_tid) else begin
                    errors++;
                    $display("Error: thread_id_out_ic exp %h got %h", exp_tid, ic_out);
                end
            end
            // lowest waiting requester wins
            assert (g_rt == first_set(wait_rt)) else begin
                errors++;
                $display("Error: core_id_rt2ic exp %h got %h", first_set(wait_rt), g_rt);
            end
            // IC requests stay pending while a load runs
            exp_g_ic = loading_tb ? 4'b0 : first_set(wait_ic);
            assert (g_ic == exp_g_ic) else begin
                errors++;
                $display("Error: core_id_ic2rt exp %h got %h", exp_g_ic, g_ic);
            end
            exp_pd = (done_total == cur_n && cur_n != 0);
            assert (pd == exp_pd) else begin
                errors++;
                $display("Error: patch_done exp %h got %h", exp_pd, pd);
            end
            if (pd) begin
                done_total = 0;
                patch_seen = 1;
            end
            done_total += $countones(td);
            for (int i = 0; i < NUM_RT; i++) begin
                if (g_rt[i]) begin
                    q_ic.push_back(rt_ctx_in[i].tid);
                    exp_pc[rt_ctx_in[i].tid] = rt_ctx_in[i].pc;
                    exp_sp[rt_ctx_in[i].tid] = rt_ctx_in[i].sp;
                end
                if (g_ic[i]) q_rt.push_back(thread_id_in_ic[i]);
            end
            #1;
            task_done_rt = '0;
            context_switch_rt = '0;
            context_switch_ic = '0;
            for (int i = 0; i < NUM_RT; i++) begin
                if (d_rt[i]) begin
                    rt_st[i] = 1;
                    rt_tid[i] = job.tid;
                    rt_cnt[i] = 1 + $urandom % 4;
                end else if (rt_st[i] == 3 || (rt_st[i] == 2 && g_rt[i])) begin
                    rt_st[i] = 0;
                end else if (rt_st[i] == 1 && !stall_rt) begin
                    if (rt_cnt[i] > 1) begin
                        rt_cnt[i]--;
                    end else if (sw_cnt[rt_tid[i]] < 2 && $urandom % 2 == 1) begin
                        // switch out to an IC core with fresh pc and sp
                        sw_cnt[rt_tid[i]]++;
                        rt_ctx_in[i].tid = rt_tid[i];
                        rt_ctx_in[i].pc = $urandom;
                        rt_ctx_in[i].sp = $urandom;
                        context_switch_rt[i] = 1'b1;
                        rt_st[i] = 2;
                    end else begin
                        task_done_rt[i] = 1'b1;
                        fin_cnt[rt_tid[i]]++;
                        rt_st[i] = 3;
                    end
                end
            end
            for (int i = 0; i < NUM_IC; i++) begin
                if (d_ic[i]) begin
                    ic_st[i] = 1;
                    thread_id_in_ic[i] = ic_out;
                    ic_cnt[i] = 1 + $urandom % 4;
                end else if (ic_st[i] == 2 && g_ic[i]) begin
                    ic_st[i] = 0;
                end else if (ic_st[i] == 1) begin
                    if (ic_cnt[i] > 1) begin
                        ic_cnt[i]--;
                    end else begin
                        context_switch_ic[i] = 1'b1;
                        ic_st[i] = 2;
                    end
                end
            end
        end
    end

    task automatic run_patch(input int n, input int stall);
        int err0;
        int cyc;
        err0 = errors;
        for (int t = 0; t < NUM_THREAD; t++) begin
            sw_cnt[t] = 0;
            fin_cnt[t] = 0;
        end
        cur_n = n;
        patch_seen = 0;
        stall_rt = (stall > 0);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #1;
            load_cp = (k == 0);
            loading_tb = 1;
            pixel_id_cp = $urandom;
            exp_pix[k] = pixel_id_cp;
            exp_pc[k] = '0;
            exp_sp[k] = '0;
            q_rt.push_back(k);
        end
        @(posedge clk);
        #1;
        load_cp = 0;
        load_done_cp = 1;
        @(posedge clk);
        #1;
        load_done_cp = 0;
        loading_tb = 0;
        if (stall > 0) begin
            repeat (stall) @(posedge clk);
            #1;
            // rest must still be queued behind the held RT cores
            assert (q_rt.size() == n - NUM_RT) else begin
                errors++;
                $display("Error: rt queue size exp %h got %h", n - NUM_RT, q_rt.size());
            end
            stall_rt = 0;
        end
        cyc = 0;
        while (!patch_seen && cyc < 5000) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!patch_seen) begin
            timed_out = 1;
            $display("timeout waiting for patch_done");
        end else begin
            for (int t = 0; t < n; t++) begin
                assert (fin_cnt[t] == 1) else begin
                    errors++;
                    $display("Error: fin_cnt[%0d] exp %h got %h", t, 1, fin_cnt[t]);
                end
            end
            tests++;
            $display("test patch of %0d threads: %0d errors", n, errors - err0);
        end
    endtask

    initial begin
        void'($urandom(46925));
        clk = 0;
        rst_n = 0;
        load_cp = 0;
        load_done_cp = 0;
        pixel_id_cp = '0;
        task_done_rt = '0;
        context_switch_rt = '0;
        context_switch_ic = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            rt_ctx_in[i] = '0;
            thread_id_in_ic[i] = '0;
            rt_st[i] = 0;
            ic_st[i] = 0;
        end
        for (int t = 0; t < NUM_THREAD; t++) begin
            exp_pix[t] = '0;
            exp_pc[t] = '0;
            exp_sp[t] = '0;
        end
        errors = 0;
        tests = 0;
        done_total = 0;
        cur_n = 0;
        timed_out = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1;
        @(posedge clk);
        #1;
        // idle outputs after reset
        assert ({job_dispatch_rt, job_dispatch_ic, core_id_rt2ic, core_id_ic2rt, patch_done}
                == '0) else begin
            errors++;
            $display("Error: outputs after reset exp %h got %h", 17'h0,
                     {job_dispatch_rt, job_dispatch_ic, core_id_rt2ic, core_id_ic2rt,
                      patch_done});
        end
        tests++;
        $display("test reset: %0d errors", errors);
        run_patch(12, 40);
        if (!timed_out) begin
            run_patch(NUM_THREAD, 0);
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/patch_pkg.sv
logic/patch_dispatcher_fifo.sv
logic/switch_arbiter.sv
logic/thread_context_store.sv
logic/patch_loader.sv
logic/patch_dispatcher.sv
testbench/patch_dispatcher_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dispatcher testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module patch_dispatcher_tb \
    -f flist.f -o patch_dispatcher_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/patch_dispatcher_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1
